/* verilog.f */
hw/cpu_pkg.sv
hw/cond_eval.sv
hw/branch_controller.sv
hw/status_flags.sv
hw/program_counter.sv
hw/branch_unit_top.sv
test/branch_unit_sva.sv
test/branch_unit_tb.sv

/* Makefile */
VERILATOR ?= verilator
FILELIST  ?= verilog.f
TB_TOP    ?= branch_unit_tb
RTL_TOP   ?= branch_unit_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
LINTFLAGS ?= -Wall
FAIL_MSG  ?= Test failed
PASS_MSG  ?= Test passed

RTL_SRCS := $(filter hw/%,$(shell cat $(FILELIST)))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINTFLAGS) $(RTL_SRCS) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(OBJ_DIR) -o V$(TB_TOP)
	-./$(OBJ_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not finish"; exit 1; fi
	@echo "simulation PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* test/branch_unit_tb.sv */
`timescale 1ns/1ps

module branch_unit_tb;

    import cpu_pkg::*;

    localparam int RESET_CYCLES = 16;
    localparam int RAND_CYCLES = 2000;
    // ten percent headroom over the random phase also covers the reset phase
    localparam int TIMEOUT_CYCLES = RAND_CYCLES + RAND_CYCLES / 10;

    logic            clk;
    logic            rst_n;
    logic            instr_valid;
    branch_instr_t   instr;
    logic            flag_wr;
    status_flags_t   flags_in;
    logic            stall;
    logic            take_branch;
    logic            flush;
    logic [WORD-1:0] pc;

    logic [31:0]     lfsr_state;
    int              cycle_count;
    status_flags_t   model_flags;
    logic [WORD-1:0] model_pc;

    branch_unit_top DUT (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .flag_wr_i     (flag_wr),
        .flags_i       (flags_in),
        .stall_i       (stall),
        .take_branch_o (take_branch),
        .flush_o       (flush),
        .pc_o          (pc)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // random source and reference model
    ////////////////////////////////////////////////////////////////////////////

    // taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic take_bits(input int count, output logic [31:0] bits);
        bits = '0;
        repeat (count) begin
            bits = {bits[30:0], lfsr_state[31]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic logic cond_holds(input cond_e cond, input status_flags_t f);
        case (cond)
            EQ: return f.zero;
            NE: return !f.zero;
            CS: return f.carry;
            CC: return !f.carry;
            MI: return f.negative;
            PL: return !f.negative;
            VS: return f.overflow;
            VC: return !f.overflow;
            HI: return f.carry && !f.zero;
            LS: return !f.carry || f.zero;
            GE: return f.negative == f.overflow;
            LT: return f.negative != f.overflow;
            GT: return !f.zero && (f.negative == f.overflow);
            LE: return f.zero || (f.negative != f.overflow);
            AL: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic model_taken(input logic valid, input branch_instr_t ins,
                                         input status_flags_t f);
        if (!valid) begin
            return 1'b0;
        end
        if (ins.op == OP_UNCOND_BRANCH) begin
            return 1'b1;
        end
        if (ins.op == OP_COND_BRANCH) begin
            return cond_holds(ins.cond, f);
        end
        return 1'b0;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic stop_on_error();
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_strobe(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error at %0t: %s expected %0b, got %0b", $realtime, name, exp, got);
            stop_on_error();
        end
    endtask

    task automatic check_pc(input logic [WORD-1:0] got, input logic [WORD-1:0] exp);
        if (got !== exp) begin
            $display("Error at %0t: pc_o expected %08h, got %08h", $realtime, exp, got);
            stop_on_error();
        end
    endtask

    task automatic check_flags_effect(input status_flags_t f);
        logic exp;
        exp = model_taken(instr_valid, instr, f);
        if (take_branch !== exp) begin
            $display("Error at %0t: take_branch_o expected %0b, got %0b (op %s cond %s nzcv %04b)",
                     $realtime, exp, take_branch, instr.op.name(), instr.cond.name(), f);
            stop_on_error();
        end
    endtask

    task automatic check_assertions();
        if (DUT.u_branch_unit_sva.fail_count != 0) begin
            $display("a bound assertion on the branch unit failed before %0t", $realtime);
            stop_on_error();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus and per-cycle checking
    ////////////////////////////////////////////////////////////////////////////

    task automatic drive_random();
        logic [31:0]   bits;
        branch_instr_t ins;
        take_bits(2, bits);
        instr_valid <= (bits[1:0] != 2'b00);
        take_bits(2, bits);
        case (bits[1:0])
            2'd0:    ins.op = OP_OTHER;
            2'd2:    ins.op = OP_UNCOND_BRANCH;
            default: ins.op = OP_COND_BRANCH;
        endcase
        take_bits(4, bits);
        ins.cond = cond_e'(bits[3:0]);
        take_bits(8, bits);
        ins.imm = {{24{bits[7]}}, bits[7:0]};
        take_bits(2, bits);
        if (bits[1:0] == 2'b00) begin
            // close to the top of memory so that the target wraps
            take_bits(8, bits);
            ins.pc = {24'hFF_FFFF, bits[7:1], 1'b0};
        end else begin
            take_bits(32, bits);
            ins.pc = {bits[31:1], 1'b0};
        end
        instr <= ins;
        take_bits(1, bits);
        flag_wr <= bits[0];
        take_bits(4, bits);
        flags_in <= status_flags_t'(bits[3:0]);
        take_bits(2, bits);
        stall <= (bits[1:0] == 2'b11);
    endtask

    task automatic check_cycle();
        status_flags_t   fwd;
        logic            exp_taken;
        fwd = flag_wr ? flags_in : model_flags;
        exp_taken = model_taken(instr_valid, instr, fwd);
        check_flags_effect(fwd);
        check_strobe("flush_o", flush, exp_taken);
        check_pc(pc, model_pc);
        check_assertions();
        // state after the coming edge
        if (exp_taken) begin
            model_pc = instr.pc + PC_AHEAD + instr.imm;
        end else if (!stall) begin
            model_pc = model_pc + PC_STEP;
        end
        if (flag_wr) begin
            model_flags = flags_in;
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("timeout: the run went past %0d clock cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        lfsr_state = 32'h5973;
        cycle_count = 0;
        rst_n = 1'b0;
        instr_valid = 1'b0;
        instr = '0;
        flag_wr = 1'b0;
        flags_in = '0;
        stall = 1'b0;
        model_flags = '0;
        model_pc = RESET_PC;

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_pc(pc, RESET_PC);
            check_strobe("take_branch_o", take_branch, 1'b0);
            check_strobe("flush_o", flush, 1'b0);
        end

        // the release edge still sees reset, so pc stays at RESET_PC
        @(posedge clk);
        rst_n <= 1'b1;
        repeat (RAND_CYCLES) begin
            drive_random();
            @(negedge clk);
            check_cycle();
            @(posedge clk);
        end

        // assertions on the last edge have reported by the next falling edge
        @(negedge clk);
        if (DUT.u_branch_unit_sva.fail_count == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1, "%0d assertions failed", DUT.u_branch_unit_sva.fail_count);
        end
    end

endmodule

/* test/branch_unit_sva.sv */
`timescale 1ns/1ps

module branch_unit_sva (
    input logic                     clk_i,
    input logic                     rst_n_i,
    input logic                     instr_valid_i,
    input logic                     take_branch_o,
    input logic                     flush_o,
    input logic [cpu_pkg::WORD-1:0] target_i,
    input logic [cpu_pkg::WORD-1:0] pc_o
);

    int unsigned fail_count = 0;

    // both strobes come from a single decision
    flush_follows_take: assert property (@(posedge clk_i) flush_o == take_branch_o)
        else begin
            $error("flush_o and take_branch_o disagree");
            fail_count = fail_count + 1;
        end

    no_strobe_when_idle: assert property (
        @(posedge clk_i) !instr_valid_i |-> !take_branch_o && !flush_o
    ) else begin
        $error("strobe raised without a valid instruction");
        fail_count = fail_count + 1;
    end

    // a taken branch must land on its target at the next edge
    redirect_lands: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        take_branch_o |=> pc_o == $past(target_i)
    ) else begin
        $error("pc_o did not load the branch target");
        fail_count = fail_count + 1;
    end

endmodule

bind branch_unit_top branch_unit_sva u_branch_unit_sva (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .instr_valid_i (instr_valid_i),
    .take_branch_o (take_branch_o),
    .flush_o       (flush_o),
    .target_i      (branch_target),
    .pc_o          (pc_o)
);

/* hw/branch_unit_top.sv */
`timescale 1ns/1ps

module branch_unit_top (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       instr_valid_i,
    input  cpu_pkg::branch_instr_t     instr_i,
    input  logic                       flag_wr_i,
    input  cpu_pkg::status_flags_t     flags_i,
    input  logic                       stall_i,
    output logic                       take_branch_o,
    output logic                       flush_o,
    output logic [cpu_pkg::WORD-1:0]   pc_o
);

    import cpu_pkg::*;

    // flags after the execute-stage bypass
    status_flags_t   flags_fwd;
    logic [WORD-1:0] branch_target;

    status_flags u_status_flags (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .flag_wr_i (flag_wr_i),
        .flags_i   (flags_i),
        .flags_o   (flags_fwd)
    );

    branch_controller u_branch_controller (
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .flags_i       (flags_fwd),
        .take_branch_o (take_branch_o),
        .flush_o       (flush_o),
        .target_o      (branch_target)
    );

    program_counter u_program_counter (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .stall_i    (stall_i),
        .redirect_i (take_branch_o),
        .target_i   (branch_target),
        .pc_o       (pc_o)
    );

endmodule

/* hw/program_counter.sv */
`timescale 1ns/1ps

module program_counter (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     stall_i,
    input  logic                     redirect_i,
    input  logic [cpu_pkg::WORD-1:0] target_i,
    output logic [cpu_pkg::WORD-1:0] pc_o
);

    import cpu_pkg::*;

    logic [WORD-1:0] pc_q;

    ////////////////////////////////////////////////////////////////////////////
    // fetch address register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pc_q <= RESET_PC;
        end else if (redirect_i) begin
            // a taken branch wins over a stall
            pc_q <= target_i;
        end else if (!stall_i) begin
            pc_q <= pc_q + PC_STEP;
        end
    end

    assign pc_o = pc_q;

endmodule

/* hw/status_flags.sv */
`timescale 1ns/1ps

module status_flags (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   flag_wr_i,
    input  cpu_pkg::status_flags_t flags_i,
    output cpu_pkg::status_flags_t flags_o
);

    import cpu_pkg::*;

    status_flags_t flags_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            flags_q <= '0;
        end else if (flag_wr_i) begin
            flags_q <= flags_i;
        end
    end

    // a compare in execute and a branch behind it resolve in the same cycle
    // so the incoming write is bypassed around the register
    assign flags_o = flag_wr_i ? flags_i : flags_q;

endmodule

/* hw/branch_controller.sv */
`timescale 1ns/1ps

module branch_controller (
    input  logic                       instr_valid_i,
    input  cpu_pkg::branch_instr_t     instr_i,
    input  cpu_pkg::status_flags_t     flags_i,
    output logic                       take_branch_o,
    output logic                       flush_o,
    output logic [cpu_pkg::WORD-1:0]   target_o
);

    import cpu_pkg::*;

    logic cond_pass;
    logic is_taken;

    cond_eval u_cond_eval (
        .cond_i  (instr_i.cond),
        .flags_i (flags_i),
        .pass_o  (cond_pass)
    );

    ////////////////////////////////////////////////////////////////////////////
    // branch decision
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (instr_i.op)
            OP_COND_BRANCH:   is_taken = cond_pass;
            OP_UNCOND_BRANCH: is_taken = 1'b1;
            default:          is_taken = 1'b0;
        endcase
    end

    // flush follows the taken strobe so the younger fetches get dropped
    assign take_branch_o = instr_valid_i & is_taken;
    assign flush_o       = instr_valid_i & is_taken;

    ////////////////////////////////////////////////////////////////////////////
    // target address
    ////////////////////////////////////////////////////////////////////////////

    // offset is relative to the pc the instruction sees, wraps at the word width
    assign target_o = instr_i.pc + PC_AHEAD + instr_i.imm;

endmodule

/* hw/cond_eval.sv */
`timescale 1ns/1ps

module cond_eval (
    input  cpu_pkg::cond_e         cond_i,
    input  cpu_pkg::status_flags_t flags_i,
    output logic                   pass_o
);

    import cpu_pkg::*;

    logic n_eq_v;

    // signed compares all hinge on whether N matches V
    assign n_eq_v = (flags_i.negative == flags_i.overflow);

    always_comb begin
        unique case (cond_i)
            EQ: pass_o = flags_i.zero;
            NE: pass_o = ~flags_i.zero;
            CS: pass_o = flags_i.carry;
            CC: pass_o = ~flags_i.carry;
            MI: pass_o = flags_i.negative;
            PL: pass_o = ~flags_i.negative;
            VS: pass_o = flags_i.overflow;
            VC: pass_o = ~flags_i.overflow;
            // unsigned higher and lower-or-same
            HI: pass_o = flags_i.carry & ~flags_i.zero;
            LS: pass_o = ~flags_i.carry | flags_i.zero;
            GE: pass_o = n_eq_v;
            LT: pass_o = ~n_eq_v;
            GT: pass_o = ~flags_i.zero & n_eq_v;
            LE: pass_o = flags_i.zero | ~n_eq_v;
            AL: pass_o = 1'b1;
            // NV is reserved and never taken
            NV: pass_o = 1'b0;
            default: pass_o = 1'b0;
        endcase
    end

endmodule

/* hw/cpu_pkg.sv */
package cpu_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths and fetch constants
    ////////////////////////////////////////////////////////////////////////////

    localparam int unsigned WORD = 32;

    // first fetch address after reset
    localparam logic [WORD-1:0] RESET_PC = 32'h0000_0000;

    // thumb instructions are halfwords so fetch steps by two bytes
    localparam logic [WORD-1:0] PC_STEP = 32'd2;

    // the pc an instruction reads is its own address plus four
    localparam logic [WORD-1:0] PC_AHEAD = 32'd4;

    ////////////////////////////////////////////////////////////////////////////
    // operation and condition encodings
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        OP_OTHER         = 2'd0,
        OP_COND_BRANCH   = 2'd1,
        OP_UNCOND_BRANCH = 2'd2
    } op_class_e;

    // condition field as it appears in the instruction
    typedef enum logic [3:0] {
        EQ = 4'h0,
        NE = 4'h1,
        CS = 4'h2,
        CC = 4'h3,
        MI = 4'h4,
        PL = 4'h5,
        VS = 4'h6,
        VC = 4'h7,
        HI = 4'h8,
        LS = 4'h9,
        GE = 4'hA,
        LT = 4'hB,
        GT = 4'hC,
        LE = 4'hD,
        AL = 4'hE,
        NV = 4'hF
    } cond_e;

    ////////////////////////////////////////////////////////////////////////////
    // bundles
    ////////////////////////////////////////////////////////////////////////////

    // nzcv with negative in the top bit
    typedef struct packed {
        logic negative;
        logic zero;
        logic carry;
        logic overflow;
    } status_flags_t;

    // decoded branch candidate as handed over by decode
    typedef struct packed {
        logic [WORD-1:0] pc;
        op_class_e       op;
        cond_e           cond;
        logic [WORD-1:0] imm;
    } branch_instr_t;

endpackage
